// ==== source/rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== source/rv_core_pkg.sv ====
`include "rv_core_params.svh"

package rv_core_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
		alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
	} alu_op_e;

	// br_none must stay the zero encoding
	typedef enum logic [3:0] {
		br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jal, br_jalr
	} br_op_e;

	typedef enum logic [1:0] {
		mem_none, mem_load, mem_store
	} mem_op_e;

	typedef enum logic [1:0] {
		idle_req, wait_rsp, wait_done, halted
	} fetch_state_e;

	typedef enum logic [1:0] {
		idle, mem_req, mem_rsp
	} result_state_e;

	typedef struct packed {
		word_t     pc;
		word_t     rs1;
		word_t     rs2;
		word_t     imm;
		reg_addr_t rd;
		logic      we;
		alu_op_e   alu_op;
		logic      a_is_pc;   // auipc
		logic      b_is_imm;
		br_op_e    br_op;
		mem_op_e   mem_op;
		logic      ebreak;
	} decoded_t;

	typedef struct packed {
		word_t     pc;
		word_t     alu_result;  // also the lw/sw address
		word_t     store_data;
		reg_addr_t rd;
		logic      we;
		mem_op_e   mem_op;
		word_t     next_pc;
		logic      ebreak;
	} exec_t;

	typedef struct packed {
		word_t     pc;
		reg_addr_t rd;
		word_t     wdata;
		logic      we;
	} retire_t;

endpackage

// ==== source/rv_fetch.sv ====
`include "rv_core_params.svh"

module rv_fetch (
	input  logic               clk,
	input  logic               reset_i,
	output logic               imem_req_valid_o,
	input  logic               imem_req_ready_i,
	output rv_core_pkg::word_t imem_addr_o,
	input  logic               imem_rsp_valid_i,
	input  rv_core_pkg::word_t imem_rsp_data_i,
	output logic               inst_valid_o,
	output rv_core_pkg::word_t inst_o,
	output rv_core_pkg::word_t pc_o,
	input  logic               done_i,
	input  rv_core_pkg::word_t next_pc_i,
	input  logic               halt_i
);

	rv_core_pkg::fetch_state_e state_q;
	rv_core_pkg::word_t        pc_q;
	logic                      req_valid_q;

	assign imem_req_valid_o = req_valid_q;
	assign imem_addr_o = pc_q;
	assign pc_o = pc_q;   // stays put until the instruction is done

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= rv_core_pkg::idle_req;
			pc_q <= `RV_RESET_PC;
			req_valid_q <= 1'b0;
			inst_valid_o <= 1'b0;
		end else begin
			inst_valid_o <= 1'b0;
			if (halt_i) begin
				// finish or illegal, nothing more is fetched
				state_q <= rv_core_pkg::halted;
				req_valid_q <= 1'b0;
			end else begin
				case (state_q)
					rv_core_pkg::idle_req: begin
						if (!req_valid_q) begin
							req_valid_q <= 1'b1;   // first request after reset
						end else if (imem_req_ready_i) begin
							req_valid_q <= 1'b0;
							state_q <= rv_core_pkg::wait_rsp;
						end
					end
					rv_core_pkg::wait_rsp: begin
						if (imem_rsp_valid_i) begin
							inst_valid_o <= 1'b1;
							state_q <= rv_core_pkg::wait_done;
						end
					end
					rv_core_pkg::wait_done: begin
						if (done_i) begin
							pc_q <= next_pc_i;
							req_valid_q <= 1'b1;
							state_q <= rv_core_pkg::idle_req;
						end
					end
					default: ;   // halted
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == rv_core_pkg::wait_rsp && imem_rsp_valid_i)
			inst_o <= imem_rsp_data_i;
	end

	// request must stay up with a fixed address until the memory takes it
	req_held: assert property (@(posedge clk) disable iff (reset_i)
		imem_req_valid_o && !imem_req_ready_i |=> imem_req_valid_o && $stable(imem_addr_o));

endmodule

// ==== source/rv_regfile.sv ====
`include "rv_core_params.svh"

module rv_regfile (
	input  logic                   clk,
	input  logic                   reset_i,
	input  rv_core_pkg::reg_addr_t rs1_addr_i,
	input  rv_core_pkg::reg_addr_t rs2_addr_i,
	output rv_core_pkg::word_t     rs1_data_o,
	output rv_core_pkg::word_t     rs2_data_o,
	input  logic                   we_i,
	input  rv_core_pkg::reg_addr_t rd_i,
	input  rv_core_pkg::word_t     wdata_i
);

	rv_core_pkg::word_t regs [`RV_NREGS];

	assign rs1_data_o = regs[rs1_addr_i];
	assign rs2_data_o = regs[rs2_addr_i];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `RV_NREGS; i++)
				regs[i] <= '0;
		end else if (we_i && rd_i != '0) begin   // x0 keeps its zero
			regs[rd_i] <= wdata_i;
		end
	end

	// whatever was written to x0 earlier, it reads back as zero
	x0_zero: assert property (@(posedge clk) disable iff (reset_i)
		rs1_addr_i == '0 |-> rs1_data_o == '0);

endmodule

// ==== source/rv_decode.sv ====
module rv_decode (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    inst_valid_i,
	input  rv_core_pkg::word_t      inst_i,
	input  rv_core_pkg::word_t      pc_i,
	output rv_core_pkg::reg_addr_t  rs1_addr_o,
	output rv_core_pkg::reg_addr_t  rs2_addr_o,
	input  rv_core_pkg::word_t      rs1_data_i,
	input  rv_core_pkg::word_t      rs2_data_i,
	output logic                    dec_valid_o,
	output rv_core_pkg::decoded_t   dec_o,
	output logic                    illegal_o
);

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	rv_core_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
	rv_core_pkg::decoded_t dec_d;
	logic                  bad;

	// funct3 to alu operation, alt picks sub and sra
	function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_sel = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
			3'b001:  alu_sel = rv_core_pkg::alu_sll;
			3'b010:  alu_sel = rv_core_pkg::alu_slt;
			3'b011:  alu_sel = rv_core_pkg::alu_sltu;
			3'b100:  alu_sel = rv_core_pkg::alu_xor;
			3'b101:  alu_sel = alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
			3'b110:  alu_sel = rv_core_pkg::alu_or;
			default: alu_sel = rv_core_pkg::alu_and;
		endcase
	endfunction

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		dec_d = '0;   // alu_add, br_none, mem_none
		dec_d.pc = pc_i;
		dec_d.rs1 = rs1_data_i;
		dec_d.rs2 = rs2_data_i;
		dec_d.rd = inst_i[11:7];
		bad = 1'b0;
		case (opcode)
			7'b0110111: begin   // lui
				dec_d.imm = imm_u;
				dec_d.we = 1'b1;
				dec_d.b_is_imm = 1'b1;
				dec_d.alu_op = rv_core_pkg::alu_pass_b;
			end
			7'b0010111: begin   // auipc
				dec_d.imm = imm_u;
				dec_d.we = 1'b1;
				dec_d.a_is_pc = 1'b1;
				dec_d.b_is_imm = 1'b1;
			end
			7'b1101111: begin
				dec_d.imm = imm_j;
				dec_d.we = 1'b1;
				dec_d.br_op = rv_core_pkg::br_jal;
			end
			7'b1100111: begin   // jalr target comes out of the alu add
				dec_d.imm = imm_i;
				dec_d.we = 1'b1;
				dec_d.b_is_imm = 1'b1;
				dec_d.br_op = rv_core_pkg::br_jalr;
				bad = funct3 != 3'b000;
			end
			7'b1100011: begin
				dec_d.imm = imm_b;
				case (funct3)
					3'b000:  dec_d.br_op = rv_core_pkg::br_beq;
					3'b001:  dec_d.br_op = rv_core_pkg::br_bne;
					3'b100:  dec_d.br_op = rv_core_pkg::br_blt;
					3'b101:  dec_d.br_op = rv_core_pkg::br_bge;
					3'b110:  dec_d.br_op = rv_core_pkg::br_bltu;
					3'b111:  dec_d.br_op = rv_core_pkg::br_bgeu;
					default: bad = 1'b1;
				endcase
			end
			7'b0000011: begin   // lw only
				dec_d.imm = imm_i;
				dec_d.we = 1'b1;
				dec_d.b_is_imm = 1'b1;
				dec_d.mem_op = rv_core_pkg::mem_load;
				bad = funct3 != 3'b010;
			end
			7'b0100011: begin   // sw only
				dec_d.imm = imm_s;
				dec_d.b_is_imm = 1'b1;
				dec_d.mem_op = rv_core_pkg::mem_store;
				bad = funct3 != 3'b010;
			end
			7'b0010011: begin
				dec_d.imm = imm_i;
				dec_d.we = 1'b1;
				dec_d.b_is_imm = 1'b1;
				dec_d.alu_op = alu_sel(funct3, funct3 == 3'b101 && inst_i[30]);
				if (funct3 == 3'b001)
					bad = funct7 != 7'b0000000;
				else if (funct3 == 3'b101)
					bad = funct7 != 7'b0000000 && funct7 != 7'b0100000;
			end
			7'b0110011: begin
				dec_d.we = 1'b1;
				dec_d.alu_op = alu_sel(funct3, inst_i[30]);
				bad = !(funct7 == 7'b0000000 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			7'b1110011: begin
				dec_d.ebreak = inst_i == 32'h0010_0073;
				bad = !dec_d.ebreak;   // no ecall or csr here
			end
			default: bad = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			dec_valid_o <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			dec_valid_o <= inst_valid_i && !bad;
			if (inst_valid_i && bad)
				illegal_o <= 1'b1;   // sticky
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid_i)
			dec_o <= dec_d;
	end

endmodule

// ==== source/rv_execute.sv ====
module rv_execute (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  dec_valid_i,
	input  rv_core_pkg::decoded_t dec_i,
	output logic                  ex_valid_o,
	output rv_core_pkg::exec_t    ex_o
);

	rv_core_pkg::word_t op_a, op_b, alu_res;
	rv_core_pkg::word_t pc_plus4, br_target;
	rv_core_pkg::exec_t ex_d;
	logic               is_jump;
	logic               taken;

	assign op_a = dec_i.a_is_pc ? dec_i.pc : dec_i.rs1;
	assign op_b = dec_i.b_is_imm ? dec_i.imm : dec_i.rs2;
	assign pc_plus4 = dec_i.pc + 32'd4;
	assign br_target = dec_i.pc + dec_i.imm;
	assign is_jump = dec_i.br_op == rv_core_pkg::br_jal || dec_i.br_op == rv_core_pkg::br_jalr;

	always_comb begin
		case (dec_i.alu_op)
			rv_core_pkg::alu_sub:    alu_res = op_a - op_b;
			rv_core_pkg::alu_sll:    alu_res = op_a << op_b[4:0];
			rv_core_pkg::alu_slt:    alu_res = rv_core_pkg::word_t'($signed(op_a) < $signed(op_b));
			rv_core_pkg::alu_sltu:   alu_res = rv_core_pkg::word_t'(op_a < op_b);
			rv_core_pkg::alu_xor:    alu_res = op_a ^ op_b;
			rv_core_pkg::alu_srl:    alu_res = op_a >> op_b[4:0];
			rv_core_pkg::alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
			rv_core_pkg::alu_or:     alu_res = op_a | op_b;
			rv_core_pkg::alu_and:    alu_res = op_a & op_b;
			rv_core_pkg::alu_pass_b: alu_res = op_b;
			default:                 alu_res = op_a + op_b;
		endcase
	end

	// branches always compare the two register values
	always_comb begin
		case (dec_i.br_op)
			rv_core_pkg::br_beq:  taken = dec_i.rs1 == dec_i.rs2;
			rv_core_pkg::br_bne:  taken = dec_i.rs1 != dec_i.rs2;
			rv_core_pkg::br_blt:  taken = $signed(dec_i.rs1) < $signed(dec_i.rs2);
			rv_core_pkg::br_bge:  taken = $signed(dec_i.rs1) >= $signed(dec_i.rs2);
			rv_core_pkg::br_bltu: taken = dec_i.rs1 < dec_i.rs2;
			rv_core_pkg::br_bgeu: taken = dec_i.rs1 >= dec_i.rs2;
			rv_core_pkg::br_jal:  taken = 1'b1;
			default:              taken = 1'b0;
		endcase
	end

	always_comb begin
		ex_d.pc = dec_i.pc;
		ex_d.alu_result = is_jump ? pc_plus4 : alu_res;   // link value
		ex_d.store_data = dec_i.rs2;
		ex_d.rd = dec_i.rd;
		ex_d.we = dec_i.we;
		ex_d.mem_op = dec_i.mem_op;
		ex_d.ebreak = dec_i.ebreak;
		if (dec_i.br_op == rv_core_pkg::br_jalr)
			ex_d.next_pc = {alu_res[31:1], 1'b0};   // rs1 + imm, bit 0 cleared
		else if (taken)
			ex_d.next_pc = br_target;
		else
			ex_d.next_pc = pc_plus4;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			ex_valid_o <= 1'b0;
		else
			ex_valid_o <= dec_valid_i;
	end

	always_ff @(posedge clk) begin
		if (dec_valid_i)
			ex_o <= ex_d;
	end

	// one instruction in flight, decode never overruns execute
	no_overrun: assert property (@(posedge clk) disable iff (reset_i)
		dec_valid_i |-> !ex_valid_o);

endmodule

// ==== source/rv_result.sv ====
module rv_result (
	input  logic                   clk,
	input  logic                   reset_i,
	input  logic                   ex_valid_i,
	input  rv_core_pkg::exec_t     ex_i,
	output logic                   dmem_req_valid_o,
	input  logic                   dmem_req_ready_i,
	output logic                   dmem_req_write_o,
	output rv_core_pkg::word_t     dmem_req_addr_o,
	output rv_core_pkg::word_t     dmem_req_wdata_o,
	input  logic                   dmem_rsp_valid_i,
	input  rv_core_pkg::word_t     dmem_rsp_rdata_i,
	output logic                   rf_we_o,
	output rv_core_pkg::reg_addr_t rf_rd_o,
	output rv_core_pkg::word_t     rf_wdata_o,
	output logic                   done_o,
	output rv_core_pkg::word_t     next_pc_o,
	output logic                   retire_valid_o,
	output rv_core_pkg::retire_t   retire_o,
	output logic                   finish_o
);

	rv_core_pkg::result_state_e state_q;
	rv_core_pkg::exec_t         ex_q;
	rv_core_pkg::word_t         load_q;
	logic                       done_q;

	assign dmem_req_valid_o = state_q == rv_core_pkg::mem_req;
	assign dmem_req_write_o = ex_q.mem_op == rv_core_pkg::mem_store;
	assign dmem_req_addr_o = ex_q.alu_result;
	assign dmem_req_wdata_o = ex_q.store_data;

	always_comb begin
		retire_o.pc = ex_q.pc;
		retire_o.rd = ex_q.rd;
		retire_o.we = ex_q.we;
		retire_o.wdata = ex_q.mem_op == rv_core_pkg::mem_load ? load_q : ex_q.alu_result;
	end

	// write-back happens in the retire cycle
	assign rf_we_o = done_q && ex_q.we;
	assign rf_rd_o = ex_q.rd;
	assign rf_wdata_o = retire_o.wdata;
	assign done_o = done_q;
	assign retire_valid_o = done_q;
	assign next_pc_o = ex_q.next_pc;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= rv_core_pkg::idle;
			done_q <= 1'b0;
			finish_o <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				rv_core_pkg::idle: begin
					if (ex_valid_i && ex_i.mem_op == rv_core_pkg::mem_none) begin
						done_q <= 1'b1;
						if (ex_i.ebreak)
							finish_o <= 1'b1;   // stays set
					end else if (ex_valid_i) begin
						state_q <= rv_core_pkg::mem_req;
					end
				end
				rv_core_pkg::mem_req: begin
					if (dmem_req_ready_i)
						state_q <= rv_core_pkg::mem_rsp;
				end
				default: begin   // mem_rsp, stores get an empty response too
					if (dmem_rsp_valid_i) begin
						done_q <= 1'b1;
						state_q <= rv_core_pkg::idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == rv_core_pkg::idle && ex_valid_i)
			ex_q <= ex_i;
		if (state_q == rv_core_pkg::mem_rsp && dmem_rsp_valid_i)
			load_q <= dmem_rsp_rdata_i;
	end

endmodule

// ==== source/rv_core.sv ====
module rv_core (
	input  logic                 clk,
	input  logic                 reset_i,
	output logic                 imem_req_valid_o,
	input  logic                 imem_req_ready_i,
	output rv_core_pkg::word_t   imem_addr_o,
	input  logic                 imem_rsp_valid_i,
	input  rv_core_pkg::word_t   imem_rsp_data_i,
	output logic                 dmem_req_valid_o,
	input  logic                 dmem_req_ready_i,
	output logic                 dmem_req_write_o,
	output rv_core_pkg::word_t   dmem_req_addr_o,
	output rv_core_pkg::word_t   dmem_req_wdata_o,
	input  logic                 dmem_rsp_valid_i,
	input  rv_core_pkg::word_t   dmem_rsp_rdata_i,
	output logic                 retire_valid_o,
	output rv_core_pkg::retire_t retire_o,
	output logic                 finish_o,
	output logic                 illegal_o
);

	logic                   inst_valid, dec_valid, ex_valid;
	rv_core_pkg::word_t     inst, pc;
	rv_core_pkg::reg_addr_t rs1_addr, rs2_addr, rf_rd;
	rv_core_pkg::word_t     rs1_data, rs2_data, rf_wdata;
	rv_core_pkg::decoded_t  dec;
	rv_core_pkg::exec_t     ex;
	logic                   rf_we, done;
	rv_core_pkg::word_t     next_pc;

	rv_fetch u_fetch (
		.clk              ( clk                    ),
		.reset_i          ( reset_i                ),
		.imem_req_valid_o ( imem_req_valid_o       ),
		.imem_req_ready_i ( imem_req_ready_i       ),
		.imem_addr_o      ( imem_addr_o            ),
		.imem_rsp_valid_i ( imem_rsp_valid_i       ),
		.imem_rsp_data_i  ( imem_rsp_data_i        ),
		.inst_valid_o     ( inst_valid             ),
		.inst_o           ( inst                   ),
		.pc_o             ( pc                     ),
		.done_i           ( done                   ),
		.next_pc_i        ( next_pc                ),
		.halt_i           ( finish_o | illegal_o   )
	);

	rv_regfile u_regfile (
		.clk        ( clk      ),
		.reset_i    ( reset_i  ),
		.rs1_addr_i ( rs1_addr ),
		.rs2_addr_i ( rs2_addr ),
		.rs1_data_o ( rs1_data ),
		.rs2_data_o ( rs2_data ),
		.we_i       ( rf_we    ),
		.rd_i       ( rf_rd    ),
		.wdata_i    ( rf_wdata )
	);

	rv_decode u_decode (
		.clk          ( clk        ),
		.reset_i      ( reset_i    ),
		.inst_valid_i ( inst_valid ),
		.inst_i       ( inst       ),
		.pc_i         ( pc         ),
		.rs1_addr_o   ( rs1_addr   ),
		.rs2_addr_o   ( rs2_addr   ),
		.rs1_data_i   ( rs1_data   ),
		.rs2_data_i   ( rs2_data   ),
		.dec_valid_o  ( dec_valid  ),
		.dec_o        ( dec        ),
		.illegal_o    ( illegal_o  )
	);

	rv_execute u_execute (
		.clk         ( clk       ),
		.reset_i     ( reset_i   ),
		.dec_valid_i ( dec_valid ),
		.dec_i       ( dec       ),
		.ex_valid_o  ( ex_valid  ),
		.ex_o        ( ex        )
	);

	rv_result u_result (
		.clk              ( clk              ),
		.reset_i          ( reset_i          ),
		.ex_valid_i       ( ex_valid         ),
		.ex_i             ( ex               ),
		.dmem_req_valid_o ( dmem_req_valid_o ),
		.dmem_req_ready_i ( dmem_req_ready_i ),
		.dmem_req_write_o ( dmem_req_write_o ),
		.dmem_req_addr_o  ( dmem_req_addr_o  ),
		.dmem_req_wdata_o ( dmem_req_wdata_o ),
		.dmem_rsp_valid_i ( dmem_rsp_valid_i ),
		.dmem_rsp_rdata_i ( dmem_rsp_rdata_i ),
		.rf_we_o          ( rf_we            ),
		.rf_rd_o          ( rf_rd            ),
		.rf_wdata_o       ( rf_wdata         ),
		.done_o           ( done             ),
		.next_pc_o        ( next_pc          ),
		.retire_valid_o   ( retire_valid_o   ),
		.retire_o         ( retire_o         ),
		.finish_o         ( finish_o         )
	);

endmodule

// ==== testbench/tb_rv_ref.svh ====
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

logic [31:0]          lfsr_state = 32'd1;
logic [31:0]          ref_dmem [256];
rv_core_pkg::retire_t exp_q [$];
int                   ref_end;   // 0 running, 1 ebreak, 2 illegal

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
	logic b;
	b = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (b)
		lfsr_state = lfsr_state ^ 32'h8020_0003;
	return b;
endfunction

function automatic logic [3:0] rand_bits(input int n);
	logic [3:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
		r = {r[2:0], lfsr_bit()};
	return r;
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, $signed(a) < $signed(b)};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: begin
			if (alt)
				return $signed(a) >>> b[4:0];   // arithmetic
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
	case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		default: return a >= b;
	endcase
endfunction

// runs the program in imem on a shadow machine, fills exp_q and ref_dmem
function automatic void run_reference();
	logic [31:0]          x [32];
	logic [31:0]          pc, in, a, b, res, nxt, addr;
	logic [31:0]          imm_i, imm_s, imm_b, imm_u, imm_j;
	logic                 wr;
	rv_core_pkg::retire_t r;
	for (int i = 0; i < 32; i++)
		x[i] = '0;
	pc = `RV_RESET_PC;
	exp_q.delete();
	ref_end = 0;
	for (int n = 0; n < 200 && ref_end == 0; n++) begin
		in = imem[pc[9:2]];
		a = x[in[19:15]];
		b = x[in[24:20]];
		imm_i = {{20{in[31]}}, in[31:20]};
		imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
		imm_b = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
		imm_u = {in[31:12], 12'b0};
		imm_j = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
		res = '0;
		wr = 1'b1;
		nxt = pc + 4;
		case (in[6:0])
			7'h37: res = imm_u;   // lui
			7'h17: res = pc + imm_u;
			7'h6f: begin
				res = pc + 4;
				nxt = pc + imm_j;
			end
			7'h67: begin
				res = pc + 4;
				nxt = (a + imm_i) & ~32'd1;
			end
			7'h63: begin
				wr = 1'b0;
				if (branch_taken(in[14:12], a, b))
					nxt = pc + imm_b;
			end
			7'h03: begin
				addr = a + imm_i;
				res = ref_dmem[addr[9:2]];
			end
			7'h23: begin
				wr = 1'b0;
				addr = a + imm_s;
				ref_dmem[addr[9:2]] = b;
			end
			7'h13: res = alu_ref(in[14:12], in[14:12] == 3'd5 && in[30], a, imm_i);
			7'h33: res = alu_ref(in[14:12], in[30], a, b);
			7'h73: begin
				wr = 1'b0;
				ref_end = in == 32'h0010_0073 ? 1 : 2;
			end
			default: ref_end = 2;   // unknown opcode never retires
		endcase
		if (ref_end != 2) begin
			r.pc = pc;
			r.rd = in[11:7];
			r.wdata = res;
			r.we = wr;
			exp_q.push_back(r);
			if (wr && in[11:7] != 5'd0)
				x[in[11:7]] = res;
			pc = nxt;
		end
	end
endfunction

`endif

// ==== testbench/tb_rv_core.sv ====
`include "rv_core_params.svh"

module tb_rv_core;
	timeunit 1ns;
	timeprecision 1ps;

	logic                 clk;
	logic                 reset_i;
	logic                 imem_req_valid_o, imem_req_ready_i, imem_rsp_valid_i;
	rv_core_pkg::word_t   imem_addr_o, imem_rsp_data_i;
	logic                 dmem_req_valid_o, dmem_req_ready_i, dmem_req_write_o;
	rv_core_pkg::word_t   dmem_req_addr_o, dmem_req_wdata_o, dmem_rsp_rdata_i;
	logic                 dmem_rsp_valid_i;
	logic                 retire_valid_o, finish_o, illegal_o;
	rv_core_pkg::retire_t retire_o;

	logic [31:0]          imem [256];
	logic [31:0]          dmem [256];
	int                   load_at;
	int                   errors = 0;
	int                   retired, retired_total = 0;
	int                   cycle_cnt = 0;
	int                   cycle_limit = 200;
	rv_core_pkg::retire_t expected;
	logic                 i_busy = 1'b0, d_busy = 1'b0;
	logic [3:0]           i_wait, d_wait;
	logic [31:0]          i_word, d_word;

	`include "tb_rv_ref.svh"

	rv_core u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] encode_i(input logic [6:0] opc, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encode_s(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [31:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};   // sw
	endfunction

	function automatic logic [31:0] encode_b(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [31:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] encode_u(input logic [6:0] opc, input logic [4:0] rd,
			input logic [31:0] imm);
		return {imm[19:0], rd, opc};
	endfunction

	function automatic logic [31:0] encode_j(input logic [4:0] rd, input logic [31:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	task automatic add_word(input logic [31:0] word);
		imem[load_at] = word;
		load_at++;
	endtask

	task automatic load_program(input int p, output string name);
		int          f3s [6] = '{0, 1, 4, 5, 6, 7};
		int          ta [6] = '{1, 1, 1, 2, 2, 1};   // operands that take the branch
		int          tb [6] = '{1, 2, 2, 1, 1, 2};
		int          na [6] = '{1, 1, 2, 1, 1, 2};   // operands that fall through
		int          nb [6] = '{2, 1, 1, 2, 2, 1};
		logic [31:0] skip;
		skip = encode_i(7'h13, 3'd0, 3, 3, 1);   // addi x3, x3, 1 marks a wrong path
		for (int i = 0; i < 256; i++)
			imem[i] = '0;
		load_at = 0;
		case (p)
			0: begin
				name = "alu";
				add_word(encode_u(7'h37, 1, 32'h12345));
				add_word(encode_i(7'h13, 3'd0, 1, 1, 32'h678));
				add_word(encode_i(7'h13, 3'd0, 2, 0, -5));
				add_word(encode_i(7'h13, 3'd0, 12, 0, 3));
				add_word(encode_u(7'h17, 3, 32'h1));
				add_word(encode_r(7'h00, 3'd0, 4, 1, 2));
				add_word(encode_r(7'h20, 3'd0, 5, 1, 2));   // sub
				add_word(encode_r(7'h00, 3'd1, 6, 1, 12));
				add_word(encode_r(7'h00, 3'd2, 7, 2, 1));
				add_word(encode_r(7'h00, 3'd3, 8, 2, 1));
				add_word(encode_r(7'h00, 3'd4, 9, 1, 2));
				add_word(encode_r(7'h00, 3'd5, 10, 2, 12));
				add_word(encode_r(7'h20, 3'd5, 11, 2, 12));   // sra
				add_word(encode_r(7'h00, 3'd6, 13, 1, 2));
				add_word(encode_r(7'h00, 3'd7, 14, 1, 2));
				add_word(encode_i(7'h13, 3'd2, 15, 2, -1));
				add_word(encode_i(7'h13, 3'd3, 16, 2, 5));
				add_word(encode_i(7'h13, 3'd4, 17, 1, -1));
				add_word(encode_i(7'h13, 3'd6, 18, 2, 32'h0f0));
				add_word(encode_i(7'h13, 3'd7, 19, 1, 32'h7ff));
				add_word(encode_i(7'h13, 3'd1, 20, 1, 4));
				add_word(encode_i(7'h13, 3'd5, 21, 2, 8));
				add_word(encode_i(7'h13, 3'd5, 22, 2, 32'h408));   // srai
				add_word(32'h0010_0073);
			end
			1: begin
				name = "branch";
				add_word(encode_i(7'h13, 3'd0, 1, 0, -1));
				add_word(encode_i(7'h13, 3'd0, 2, 0, 1));
				for (int k = 0; k < 6; k++) begin
					add_word(encode_b(f3s[k], ta[k], tb[k], 8));
					add_word(skip);
					add_word(encode_b(f3s[k], na[k], nb[k], 8));   // not taken
				end
				add_word(encode_j(5, 8));
				add_word(skip);
				add_word(encode_u(7'h17, 6, 0));
				add_word(encode_i(7'h67, 3'd0, 7, 6, 13));   // odd target loses bit 0
				add_word(skip);
				add_word(encode_r(7'h00, 3'd0, 8, 5, 7));
				add_word(32'h0010_0073);
			end
			2: begin
				name = "memory";
				add_word(encode_i(7'h13, 3'd0, 1, 0, 32'h100));
				add_word(encode_u(7'h37, 2, 32'hdeadb));
				add_word(encode_i(7'h13, 3'd0, 2, 2, -273));
				add_word(encode_s(2, 1, 0));
				add_word(encode_i(7'h13, 3'd0, 3, 0, 32'h55));
				add_word(encode_s(3, 1, 4));
				add_word(encode_s(1, 1, -4));
				add_word(encode_i(7'h03, 3'd2, 4, 1, 0));
				add_word(encode_i(7'h03, 3'd2, 5, 1, 4));
				add_word(encode_i(7'h03, 3'd2, 6, 1, -4));
				add_word(encode_i(7'h03, 3'd2, 9, 1, 16));   // untouched fill word
				add_word(encode_r(7'h00, 3'd0, 7, 4, 5));
				add_word(encode_s(7, 1, 8));
				add_word(encode_i(7'h03, 3'd2, 8, 1, 8));
				add_word(32'h0010_0073);
			end
			3: begin
				name = "x0";
				add_word(encode_i(7'h13, 3'd0, 0, 0, 5));
				add_word(encode_u(7'h37, 0, 32'habcde));
				add_word(encode_r(7'h00, 3'd0, 1, 0, 0));
				add_word(encode_i(7'h13, 3'd0, 2, 0, 9));
				add_word(encode_j(0, 4));   // link dropped into x0
				add_word(encode_r(7'h20, 3'd0, 3, 2, 0));
				add_word(32'h0010_0073);
			end
			4: begin
				name = "ebreak";
				add_word(encode_i(7'h13, 3'd0, 1, 0, 1));
				add_word(32'h0010_0073);
				add_word(encode_i(7'h13, 3'd0, 1, 0, 2));
				add_word(encode_i(7'h13, 3'd0, 2, 0, 3));
			end
			default: begin
				name = "illegal";
				add_word(encode_i(7'h13, 3'd0, 1, 0, 3));
				add_word(32'h1234_567f);   // opcode 7f
				add_word(encode_i(7'h13, 3'd0, 2, 0, 4));
				add_word(32'h0010_0073);
			end
		endcase
	endtask

	task automatic run_program(input int p);
		string name;
		int    errs_before;
		int    tail_reqs;
		errs_before = errors;
		load_program(p, name);
		for (int i = 0; i < 256; i++) begin
			dmem[i] = ~(i << 2) ^ 32'h5a00_0000;
			ref_dmem[i] = dmem[i];
		end
		run_reference();
		cycle_limit = cycle_cnt + 40 * (exp_q.size() + 1) + 100;
		retired = 0;
		@(posedge clk);
		reset_i <= 1'b1;
		repeat (2) @(posedge clk);
		reset_i <= 1'b0;
		while (!finish_o && !illegal_o)
			@(posedge clk);
		tail_reqs = 0;
		repeat (50) begin   // core must stay quiet once halted
			@(posedge clk);
			if (imem_req_valid_o)
				tail_reqs++;
		end
		check_value("finish_o", finish_o, ref_end == 1);
		check_value("illegal_o", illegal_o, ref_end == 2);
		check_value("imem requests after halt", tail_reqs, 0);
		if (exp_q.size() != 0) begin
			$display("error: program %s left %0d instructions unretired", name, exp_q.size());
			errors++;
		end
		for (int i = 0; i < 256; i++)
			check_value($sformatf("dmem[%0h]", i * 4), dmem[i], ref_dmem[i]);
		retired_total += retired;
		$display("program %-8s %3d retired  %s", name, retired,
			errors == errs_before ? "pass" : "fail");
	endtask

	// memory models with one request in flight per port
	always @(posedge clk) begin
		imem_rsp_valid_i <= 1'b0;
		dmem_rsp_valid_i <= 1'b0;
		imem_req_ready_i <= rand_bits(2) != 4'd0;   // ready 3 of 4 cycles
		dmem_req_ready_i <= rand_bits(2) != 4'd0;
		if (reset_i) begin
			i_busy = 1'b0;
			d_busy = 1'b0;
		end else begin
			if (i_busy && i_wait == 0) begin
				imem_rsp_valid_i <= 1'b1;
				imem_rsp_data_i <= i_word;
				i_busy = 1'b0;
			end else if (i_busy) begin
				i_wait--;
			end else if (imem_req_valid_o && imem_req_ready_i) begin
				i_busy = 1'b1;
				i_wait = rand_bits(2);
				i_word = imem[imem_addr_o[9:2]];
			end
			if (d_busy && d_wait == 0) begin
				dmem_rsp_valid_i <= 1'b1;
				dmem_rsp_rdata_i <= d_word;
				d_busy = 1'b0;
			end else if (d_busy) begin
				d_wait--;
			end else if (dmem_req_valid_o && dmem_req_ready_i) begin
				d_busy = 1'b1;
				d_wait = rand_bits(2);
				d_word = dmem_req_write_o ? '0 : dmem[dmem_req_addr_o[9:2]];
				if (dmem_req_write_o)
					dmem[dmem_req_addr_o[9:2]] = dmem_req_wdata_o;
			end
		end
	end

	// compare each retire with the reference sequence
	always @(posedge clk) begin
		if (!reset_i && retire_valid_o) begin
			retired++;
			if (exp_q.size() == 0) begin
				$display("error at %0d ns: unexpected retire at pc %h", $time, retire_o.pc);
				errors++;
			end else begin
				expected = exp_q.pop_front();
				check_value("retire_o.pc", retire_o.pc, expected.pc);
				check_value("retire_o.we", retire_o.we, expected.we);
				if (expected.we) begin   // rd and wdata only mean something on a write
					check_value("retire_o.rd", retire_o.rd, expected.rd);
					check_value("retire_o.wdata", retire_o.wdata, expected.wdata);
				end
			end
		end
	end

	initial begin
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the core did not halt within %0d cycles", cycle_cnt);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		reset_i = 1'b1;
		imem_req_ready_i = 1'b0;
		imem_rsp_valid_i = 1'b0;
		imem_rsp_data_i = '0;
		dmem_req_ready_i = 1'b0;
		dmem_rsp_valid_i = 1'b0;
		dmem_rsp_rdata_i = '0;
		for (int p = 0; p < 6; p++)
			run_program(p);
		$display("6 programs, %0d retired, %0d errors", retired_total, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== rv_core.f ====
+incdir+source
+incdir+testbench
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
testbench/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_core_pkg.sv
      - source/rv_fetch.sv
      - source/rv_regfile.sv
      - source/rv_decode.sv
      - source/rv_execute.sv
      - source/rv_result.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
      - testbench
    files:
      - testbench/tb_rv_core.sv
